// ==== vlog.f ====
+incdir+include
source/dec_pkg.sv
source/inst_fields_stage.sv
source/ctrl_decode_stage.sv
source/operand_stage.sv
source/decode_pipe.sv
dv/tb_decode_pipe.sv

// ==== Makefile ====
TOP = tb_decode_pipe

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -f vlog.f --top-module decode_pipe

clean:
	rm -rf obj_dir

// ==== dv/tb_decode_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dec_cfg.svh"

module tb_decode_pipe import dec_pkg::*; ();

    localparam logic [5:0] shift_imm_fn [0:2] = '{6'h00, 6'h02, 6'h03};
    localparam logic [5:0] shift_var_fn [0:2] = '{6'h04, 6'h06, 6'h07};
    localparam logic [5:0] alu_fn [0:9] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
                                            6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    localparam logic [5:0] load_op [0:4] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25};
    localparam logic [5:0] store_op [0:2] = '{6'h28, 6'h29, 6'h2b};

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    fetch_item_t in_item;
    logic        in_ready;
    logic        out_valid;
    decoded_t    out_item;
    logic        credit_return;

    decoded_t    exp_q[$];
    int          stamp_q[$];   // edge of acceptance
    int          cyc = 0;
    int          accepted = 0;
    int          returned_applied = 0;
    int          owed = 0;     // received, credit not yet returned
    int          errors = 0;
    int          checks = 0;
    logic        hold_credits;
    string       abort_why = "";

    decode_pipe i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_item       (in_item),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_item      (out_item),
        .credit_return (credit_return)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n && credit_return) begin
            returned_applied <= returned_applied + 1;
        end
    end

    //////////////////////////////////////////////////
    // reference decoder

    function automatic alu_op_e alu_for_funct(input logic [5:0] fn);
        case (fn)
            6'h20:   return alu_add;
            6'h21:   return alu_addu;
            6'h22:   return alu_sub;
            6'h23:   return alu_subu;
            6'h24:   return alu_and;
            6'h25:   return alu_or;
            6'h26:   return alu_xor;
            6'h27:   return alu_nor;
            6'h2a:   return alu_slt;
            6'h2b:   return alu_sltu;
            default: return alu_nop;
        endcase
    endfunction

    function automatic decoded_t expect_decode(input fetch_item_t it);
        decoded_t    e;
        logic [5:0]  op;
        logic [5:0]  fn;
        reg_idx_t    f_rs;
        reg_idx_t    f_rt;
        reg_idx_t    f_rd;
        logic [15:0] off;
        data_t       sext;
        addr_t       link;
        addr_t       br_tgt;
        op     = it.raw_inst[31:26];
        fn     = it.raw_inst[5:0];
        f_rs   = it.raw_inst[25:21];
        f_rt   = it.raw_inst[20:16];
        f_rd   = it.raw_inst[15:11];
        off    = it.raw_inst[15:0];
        sext   = {{16{off[15]}}, off};
        link   = it.pc + addr_t'(`DEC_LINK_OFFSET);
        br_tgt = it.pc + addr_t'(1) + sext[`DEC_ADDR_WIDTH-1:0];
        e      = '0;
        case (op)
            6'h00: begin
                if (fn == 6'h00 && it.raw_inst[20:6] == '0) begin
                    e.alu_op = alu_nop;   // nop word
                end else if (fn == 6'h00 || fn == 6'h02 || fn == 6'h03) begin
                    e.rs     = f_rt;
                    e.rs_en  = 1'b1;
                    e.rd     = f_rd;
                    e.wb_reg = 1'b1;
                    e.alu_op = (fn == 6'h00) ? alu_sll : (fn == 6'h02) ? alu_srl : alu_sra;
                    e.imm    = data_t'(it.raw_inst[10:6]);
                    e.b_imm  = 1'b1;
                end else if (fn == 6'h04 || fn == 6'h06 || fn == 6'h07) begin
                    e.rs     = f_rt;   // operands swapped
                    e.rt     = f_rs;
                    e.rs_en  = 1'b1;
                    e.rt_en  = 1'b1;
                    e.rd     = f_rd;
                    e.wb_reg = 1'b1;
                    e.alu_op = (fn == 6'h04) ? alu_sll : (fn == 6'h06) ? alu_srl : alu_sra;
                end else if (fn == 6'h08 || fn == 6'h09) begin
                    e.rs     = f_rs;
                    e.rs_en  = 1'b1;
                    e.jump   = jmp_reg;
                    e.branch = 1'b1;
                    if (fn == 6'h09) begin
                        e.rd     = f_rd;
                        e.wb_reg = 1'b1;
                        e.alu_op = alu_addu;
                        e.imm    = data_t'(link);
                        e.b_imm  = 1'b1;
                    end
                end else if (alu_for_funct(fn) == alu_nop) begin
                    e.illegal = 1'b1;
                end else begin
                    e.rs     = f_rs;
                    e.rt     = f_rt;
                    e.rs_en  = 1'b1;
                    e.rt_en  = 1'b1;
                    e.rd     = f_rd;
                    e.wb_reg = 1'b1;
                    e.alu_op = alu_for_funct(fn);
                end
            end
            6'h01: begin
                if (f_rt == 5'd0 || f_rt == 5'd1) begin
                    e.rs     = f_rs;
                    e.rs_en  = 1'b1;
                    e.alu_op = f_rt[0] ? alu_bge : alu_blt;
                    e.target = br_tgt;
                    e.branch = 1'b1;
                end else begin
                    e.illegal = 1'b1;
                end
            end
            6'h02, 6'h03: begin
                e.alu_op = alu_addu;
                e.target = it.raw_inst[`DEC_ADDR_WIDTH-1:0];
                e.jump   = jmp_imm;
                e.branch = 1'b1;
                if (op == 6'h03) begin
                    e.rd     = reg_idx_t'(`DEC_LINK_REG);
                    e.wb_reg = 1'b1;
                    e.imm    = data_t'(link);
                    e.b_imm  = 1'b1;
                end
            end
            6'h04, 6'h05, 6'h06, 6'h07: begin
                e.rs     = f_rs;
                e.rs_en  = 1'b1;
                e.target = br_tgt;
                e.branch = 1'b1;
                case (op)
                    6'h04:   e.alu_op = alu_beq;
                    6'h05:   e.alu_op = alu_bne;
                    6'h06:   e.alu_op = alu_ble;
                    default: e.alu_op = alu_bgt;
                endcase
                if (op == 6'h04 || op == 6'h05) begin
                    e.rt    = f_rt;
                    e.rt_en = 1'b1;
                end
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                e.rs     = (op == 6'h0f) ? reg_idx_t'(0) : f_rs;
                e.rs_en  = (op != 6'h0f);
                e.rd     = f_rt;
                e.wb_reg = 1'b1;
                e.b_imm  = 1'b1;
                case (op)
                    6'h08:   e.alu_op = alu_add;
                    6'h09:   e.alu_op = alu_addu;
                    6'h0a:   e.alu_op = alu_slt;
                    6'h0b:   e.alu_op = alu_sltu;
                    6'h0c:   e.alu_op = alu_and;
                    6'h0d:   e.alu_op = alu_or;
                    6'h0e:   e.alu_op = alu_xor;
                    default: e.alu_op = alu_lu;
                endcase
                e.imm = (op == 6'h0c || op == 6'h0d || op == 6'h0e) ? {16'h0000, off} : sext;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b: begin
                e.rs     = f_rs;
                e.rs_en  = 1'b1;
                e.alu_op = alu_add;
                e.imm    = sext;
                e.b_imm  = 1'b1;
                case (op)
                    6'h20:   e.mem = load_b;
                    6'h21:   e.mem = load_h;
                    6'h23:   e.mem = load_w;
                    6'h24:   e.mem = load_bu;
                    6'h25:   e.mem = load_hu;
                    6'h28:   e.mem = store_b;
                    6'h29:   e.mem = store_h;
                    default: e.mem = store_w;
                endcase
                if (op[3]) begin   // stores
                    e.rt    = f_rt;
                    e.rt_en = 1'b1;
                end else begin
                    e.rd     = f_rt;
                    e.wb_reg = 1'b1;
                    e.wb_mem = 1'b1;
                end
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    //////////////////////////////////////////////////
    // stimulus

    function automatic data_t random_inst();
        data_t      w;
        logic [3:0] sel;
        w   = $urandom;
        sel = 4'($urandom_range(0, 9));
        case ($urandom_range(0, 13))
            0: w = '0;
            1: begin
                w[31:26] = 6'h00;
                w[5:0]   = shift_imm_fn[sel[1:0] % 2'd3];
            end
            2: begin
                w[31:26] = 6'h00;
                w[5:0]   = shift_var_fn[sel[1:0] % 2'd3];
            end
            3: begin
                w[31:26] = 6'h00;
                w[5:0]   = alu_fn[sel];
            end
            4: begin
                w[31:26] = 6'h00;
                w[5:0]   = w[6] ? 6'h09 : 6'h08;
            end
            5: w[31:26] = w[26] ? 6'h03 : 6'h02;
            6: w[31:28] = 4'b0001;   // beq bne blez bgtz
            7: begin
                w[31:26] = 6'h01;
                w[20:17] = 4'b0000;
            end
            8: w[31:29] = 3'b001;
            9: w[31:26] = load_op[sel[2:0] % 3'd5];
            10: w[31:26] = store_op[sel[1:0] % 2'd3];
            11: w[31:26] = 6'h00;    // mostly undefined funct
            12: w[31:26] = 6'h01;
            default: w = $urandom;
        endcase
        return w;
    endfunction

    task automatic finish_run(input bit aborted, input string why);
        if (aborted) begin
            $display("%s", why);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (!aborted && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic send_item();
        fetch_item_t it;
        decoded_t    e;
        int          waited;
        it.pc       = addr_t'($urandom);
        it.raw_inst = random_inst();
        e           = expect_decode(it);
        in_item     = it;
        in_valid    = 1'b1;
        waited      = 0;
        while (!in_ready && abort_why == "") begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 200) begin
                abort_why = "timeout: in_ready stayed low for 200 cycles";
            end
        end
        if (abort_why == "") begin
            @(posedge clk);
            #2;
            exp_q.push_back(e);
            stamp_q.push_back(cyc);
            accepted++;
        end
    endtask

    initial begin
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            credit_return = 1'b0;
            if (!hold_credits && owed > 0 && $urandom_range(0, 2) == 0) begin
                credit_return = 1'b1;
                owed--;
            end
        end
    end

    //////////////////////////////////////////////////
    // checking

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("** Error: out_item.%s = %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic compare_item(input decoded_t got, input decoded_t want);
        check_field("rs", 32'(got.rs), 32'(want.rs));
        check_field("rt", 32'(got.rt), 32'(want.rt));
        check_field("rd", 32'(got.rd), 32'(want.rd));
        check_field("rs_en", 32'(got.rs_en), 32'(want.rs_en));
        check_field("rt_en", 32'(got.rt_en), 32'(want.rt_en));
        check_field("wb_reg", 32'(got.wb_reg), 32'(want.wb_reg));
        check_field("alu_op", 32'(got.alu_op), 32'(want.alu_op));
        check_field("imm", got.imm, want.imm);
        check_field("target", 32'(got.target), 32'(want.target));
        check_field("b_imm", 32'(got.b_imm), 32'(want.b_imm));
        check_field("mem", 32'(got.mem), 32'(want.mem));
        check_field("wb_mem", 32'(got.wb_mem), 32'(want.wb_mem));
        check_field("jump", 32'(got.jump), 32'(want.jump));
        check_field("branch", 32'(got.branch), 32'(want.branch));
        check_field("illegal", 32'(got.illegal), 32'(want.illegal));
    endtask

    task automatic check_credit_state();
        int outstanding;
        outstanding = accepted - returned_applied;
        checks++;
        assert (outstanding >= 0 && outstanding <= `DEC_CREDITS) else begin
            $display("outstanding item count %0d is out of range", outstanding);
            errors++;
        end
        assert (in_ready == (outstanding < `DEC_CREDITS)) else begin
            $display("** Error: in_ready = %h, expected %h", in_ready,
                     (outstanding < `DEC_CREDITS));
            errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        decoded_t want;
        int       stamp;
        if (rst_n) begin
            check_credit_state();
            if (out_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("output item appeared with none outstanding");
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    want  = exp_q.pop_front();
                    stamp = stamp_q.pop_front();
                    // accepting edge registers stage one, two more edges follow
                    assert (cyc == stamp + 2) else begin
                        $display("item accepted at edge %0d came out at edge %0d", stamp, cyc);
                        errors++;
                    end
                    compare_item(out_item, want);
                    owed++;
                end
            end else if (stamp_q.size() > 0 && cyc >= stamp_q[0] + 2) begin
                $display("item accepted at edge %0d never came out", stamp_q[0]);
                errors++;
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence

    task automatic run_sequence();
        fetch_item_t extra;
        int          waited;
        @(negedge clk);
        assert (in_ready === 1'b1 && out_valid === 1'b0) else begin
            $display("** Error: after reset in_ready = %h, out_valid = %h, expected 1, 0",
                     in_ready, out_valid);
            errors++;
        end
        @(posedge clk);
        #2;

        // fill all credits with none returned
        hold_credits = 1'b1;
        repeat (`DEC_CREDITS) send_item();
        if (abort_why != "") begin
            return;
        end
        assert (!in_ready) else begin
            $display("** Error: in_ready = %h, expected 0", in_ready);
            errors++;
        end
        extra.pc       = addr_t'($urandom);
        extra.raw_inst = random_inst();
        in_item        = extra;   // must not be taken
        waited         = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 20) begin
                abort_why = "timeout: pipeline did not drain with credits held";
                return;
            end
        end
        in_valid     = 1'b0;
        hold_credits = 1'b0;

        repeat (400) begin
            if ($urandom_range(0, 3) == 0) begin
                in_valid = 1'b0;
                repeat ($urandom_range(1, 3)) begin
                    @(posedge clk);
                    #2;
                end
            end
            send_item();
            if (abort_why != "") begin
                return;
            end
        end
        in_valid = 1'b0;

        waited = 0;
        while (exp_q.size() > 0 || owed > 0 || accepted != returned_applied) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 100) begin
                abort_why = "timeout: items or credits still outstanding at the end";
                return;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h470ec2b2));
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_item      = '0;
        hold_credits = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        run_sequence();
        finish_run(abort_why != "", abort_why);
    end

endmodule

`default_nettype wire

// ==== source/decode_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dec_cfg.svh"

module decode_pipe import dec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  fetch_item_t in_item,
    output logic        in_ready,
    output logic        out_valid,
    output decoded_t    out_item,
    input  logic        credit_return
);

    logic        field_valid;
    field_item_t field_item;
    logic        ctrl_valid;
    ctrl_item_t  ctrl_item;

    //////////////////////////////////////////////////
    // three register stages, no internal stall

    inst_fields_stage i_fields (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_item       (in_item),
        .credit_return (credit_return),
        .in_ready      (in_ready),
        .field_valid   (field_valid),
        .field_item    (field_item)
    );

    ctrl_decode_stage i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .field_valid (field_valid),
        .field_item  (field_item),
        .ctrl_valid  (ctrl_valid),
        .ctrl_item   (ctrl_item)
    );

    operand_stage i_operand (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_valid (ctrl_valid),
        .ctrl_item  (ctrl_item),
        .out_valid  (out_valid),
        .out_item   (out_item)
    );

endmodule

`default_nettype wire

// ==== source/operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dec_cfg.svh"

module operand_stage import dec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ctrl_valid,
    input  ctrl_item_t ctrl_item,
    output logic       out_valid,
    output decoded_t   out_item
);

    decoded_t d;
    addr_t    link_addr;
    addr_t    branch_addr;

    assign link_addr   = ctrl_item.pc + addr_t'(`DEC_LINK_OFFSET);
    assign branch_addr = ctrl_item.pc + addr_t'(1) + addr_t'($signed(ctrl_item.imm16));

    //////////////////////////////////////////////////
    // immediate and target

    always_comb begin
        case (ctrl_item.imm_kind)
            imm_sign16: d.imm = data_t'($signed(ctrl_item.imm16));
            imm_zero16: d.imm = data_t'(ctrl_item.imm16);
            imm_shamt:  d.imm = data_t'(ctrl_item.imm16[10:6]);   // shamt field
            imm_link:   d.imm = data_t'(link_addr);
            default:    d.imm = '0;
        endcase
        case (ctrl_item.target_kind)
            tgt_branch: d.target = branch_addr;
            tgt_index:  d.target = ctrl_item.index26[`DEC_ADDR_WIDTH-1:0];   // no upper pc bits
            default:    d.target = '0;
        endcase
        d.rs      = ctrl_item.rs;
        d.rt      = ctrl_item.rt;
        d.rd      = ctrl_item.rd;
        d.rs_en   = ctrl_item.rs_en;
        d.rt_en   = ctrl_item.rt_en;
        d.wb_reg  = ctrl_item.wb_reg;
        d.alu_op  = ctrl_item.alu_op;
        d.b_imm   = ctrl_item.b_imm;
        d.mem     = ctrl_item.mem;
        d.wb_mem  = ctrl_item.wb_mem;
        d.jump    = ctrl_item.jump;
        d.branch  = ctrl_item.branch;
        d.illegal = ctrl_item.illegal;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_valid) begin
            out_item <= d;
        end
    end

endmodule

`default_nettype wire

// ==== source/ctrl_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dec_cfg.svh"

module ctrl_decode_stage import dec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        field_valid,
    input  field_item_t field_item,
    output logic        ctrl_valid,
    output ctrl_item_t  ctrl_item
);

    ctrl_item_t c;
    alu_op_e    shift_op;
    logic       is_nop;

    function automatic alu_op_e r_alu_op(input logic [5:0] funct);
        case (funct)
            6'b100000: return alu_add;
            6'b100001: return alu_addu;
            6'b100010: return alu_sub;
            6'b100011: return alu_subu;
            6'b100100: return alu_and;
            6'b100101: return alu_or;
            6'b100110: return alu_xor;
            6'b100111: return alu_nor;
            6'b101010: return alu_slt;
            6'b101011: return alu_sltu;
            default:   return alu_nop;
        endcase
    endfunction

    function automatic alu_op_e imm_alu_op(input logic [2:0] op_lo);
        case (op_lo)
            3'b000:  return alu_add;
            3'b001:  return alu_addu;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_and;
            3'b101:  return alu_or;
            3'b110:  return alu_xor;
            default: return alu_lu;
        endcase
    endfunction

    function automatic mem_e mem_of(input logic [5:0] op);
        case (op)
            6'b100000: return load_b;
            6'b100001: return load_h;
            6'b100011: return load_w;
            6'b100100: return load_bu;
            6'b100101: return load_hu;
            6'b101000: return store_b;
            6'b101001: return store_h;
            6'b101011: return store_w;
            default:   return mem_none;
        endcase
    endfunction

    // funct[1:0] picks the shift for both forms
    always_comb begin
        case (field_item.funct[1:0])
            2'b10:   shift_op = alu_srl;
            2'b11:   shift_op = alu_sra;
            default: shift_op = alu_sll;
        endcase
    end

    assign is_nop = (field_item.funct == 6'b000000) && (field_item.rt == '0) &&
                    (field_item.rd == '0) && (field_item.shamt == '0);

    //////////////////////////////////////////////////
    // decode table

    always_comb begin
        c         = '0;   // also the nop word
        c.pc      = field_item.pc;
        c.imm16   = field_item.imm16;
        c.index26 = field_item.index26;
        case (field_item.op)
            6'b000000: begin
                case (field_item.funct)
                    6'b000000, 6'b000010, 6'b000011: begin // sll srl sra
                        if (!is_nop) begin
                            c.rs       = field_item.rt;
                            c.rs_en    = 1'b1;
                            c.rd       = field_item.rd;
                            c.wb_reg   = 1'b1;
                            c.alu_op   = shift_op;
                            c.imm_kind = imm_shamt;
                            c.b_imm    = 1'b1;
                        end
                    end
                    6'b000100, 6'b000110, 6'b000111: begin // sllv srlv srav
                        c.rs     = field_item.rt;
                        c.rs_en  = 1'b1;
                        c.rt     = field_item.rs;
                        c.rt_en  = 1'b1;
                        c.rd     = field_item.rd;
                        c.wb_reg = 1'b1;
                        c.alu_op = shift_op;
                    end
                    6'b001000, 6'b001001: begin // jr jalr
                        c.rs     = field_item.rs;
                        c.rs_en  = 1'b1;
                        c.jump   = jmp_reg;
                        c.branch = 1'b1;
                        if (field_item.funct[0]) begin
                            c.rd       = field_item.rd;
                            c.wb_reg   = 1'b1;
                            c.alu_op   = alu_addu;
                            c.imm_kind = imm_link;
                            c.b_imm    = 1'b1;
                        end
                    end
                    6'b100000, 6'b100001, 6'b100010, 6'b100011, 6'b100100,
                    6'b100101, 6'b100110, 6'b100111, 6'b101010, 6'b101011: begin
                        c.rs     = field_item.rs;
                        c.rs_en  = 1'b1;
                        c.rt     = field_item.rt;
                        c.rt_en  = 1'b1;
                        c.rd     = field_item.rd;
                        c.wb_reg = 1'b1;
                        c.alu_op = r_alu_op(field_item.funct);
                    end
                    default: c.illegal = 1'b1;
                endcase
            end
            6'b000001: begin // bltz bgez
                if (field_item.rt[4:1] == '0) begin
                    c.rs          = field_item.rs;
                    c.rs_en       = 1'b1;
                    c.alu_op      = field_item.rt[0] ? alu_bge : alu_blt;
                    c.target_kind = tgt_branch;
                    c.branch      = 1'b1;
                end else begin
                    c.illegal = 1'b1;
                end
            end
            6'b000010, 6'b000011: begin // j jal
                c.alu_op      = alu_addu;
                c.target_kind = tgt_index;
                c.jump        = jmp_imm;
                c.branch      = 1'b1;
                if (field_item.op[0]) begin
                    c.rd       = reg_idx_t'(`DEC_LINK_REG);
                    c.wb_reg   = 1'b1;
                    c.imm_kind = imm_link;
                    c.b_imm    = 1'b1;
                end
            end
            6'b000100, 6'b000101, 6'b000110, 6'b000111: begin // beq bne blez bgtz
                c.rs          = field_item.rs;
                c.rs_en       = 1'b1;
                c.target_kind = tgt_branch;
                c.branch      = 1'b1;
                if (!field_item.op[1]) begin
                    c.rt     = field_item.rt;
                    c.rt_en  = 1'b1;
                    c.alu_op = field_item.op[0] ? alu_bne : alu_beq;
                end else begin
                    c.alu_op = field_item.op[0] ? alu_bgt : alu_ble;
                end
            end
            6'b001000, 6'b001001, 6'b001010, 6'b001011,
            6'b001100, 6'b001101, 6'b001110, 6'b001111: begin
                if (field_item.op[2:0] != 3'b111) begin // lui reads no register
                    c.rs    = field_item.rs;
                    c.rs_en = 1'b1;
                end
                c.rd       = field_item.rt;
                c.wb_reg   = 1'b1;
                c.alu_op   = imm_alu_op(field_item.op[2:0]);
                c.b_imm    = 1'b1;
                // andi ori xori zero-extend
                if (field_item.op[2] && field_item.op[2:0] != 3'b111) begin
                    c.imm_kind = imm_zero16;
                end else begin
                    c.imm_kind = imm_sign16;
                end
            end
            6'b100000, 6'b100001, 6'b100011, 6'b100100, 6'b100101: begin // loads
                c.rs       = field_item.rs;
                c.rs_en    = 1'b1;
                c.rd       = field_item.rt;
                c.wb_reg   = 1'b1;
                c.alu_op   = alu_add;   // base + offset
                c.imm_kind = imm_sign16;
                c.b_imm    = 1'b1;
                c.mem      = mem_of(field_item.op);
                c.wb_mem   = 1'b1;
            end
            6'b101000, 6'b101001, 6'b101011: begin // stores
                c.rs       = field_item.rs;
                c.rs_en    = 1'b1;
                c.rt       = field_item.rt;
                c.rt_en    = 1'b1;
                c.alu_op   = alu_add;
                c.imm_kind = imm_sign16;
                c.b_imm    = 1'b1;
                c.mem      = mem_of(field_item.op);
            end
            default: c.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= field_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (field_valid) begin
            ctrl_item <= c;
        end
    end

endmodule

`default_nettype wire

// ==== source/inst_fields_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dec_cfg.svh"

module inst_fields_stage import dec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  fetch_item_t in_item,
    input  logic        credit_return,
    output logic        in_ready,
    output logic        field_valid,
    output field_item_t field_item
);

    localparam int CREDIT_W = $clog2(`DEC_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;
    logic                accept;

    //////////////////////////////////////////////////
    // credit counter

    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(`DEC_CREDITS);
        end else begin
            // take and return can land on the same edge
            credits <= credits - CREDIT_W'(accept) + CREDIT_W'(credit_return);
        end
    end

    //////////////////////////////////////////////////
    // field split

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            field_valid <= 1'b0;
        end else begin
            field_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            field_item.pc      <= in_item.pc;
            field_item.op      <= in_item.raw_inst[31:26];
            field_item.rs      <= in_item.raw_inst[25:21];
            field_item.rt      <= in_item.raw_inst[20:16];
            field_item.rd      <= in_item.raw_inst[15:11];
            field_item.shamt   <= in_item.raw_inst[10:6];
            field_item.funct   <= in_item.raw_inst[5:0];
            field_item.imm16   <= in_item.raw_inst[15:0];   // also branch offset
            field_item.index26 <= in_item.raw_inst[25:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/dec_pkg.sv ====
`default_nettype none
`include "dec_cfg.svh"

package dec_pkg;

    typedef logic [`DEC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DEC_DATA_WIDTH-1:0] data_t;
    typedef logic [`DEC_REG_WIDTH-1:0]  reg_idx_t;

    //////////////////////////////////////////////////
    // encodings

    typedef enum logic [4:0] {
        alu_nop, alu_add, alu_addu, alu_sub, alu_subu,
        alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra, alu_lu,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_ble, alu_bgt
    } alu_op_e;

    typedef enum logic [1:0] {
        jmp_none, jmp_imm, jmp_reg
    } jump_e;

    typedef enum logic [3:0] {
        mem_none, load_b, load_bu, load_h, load_hu, load_w,
        store_b, store_h, store_w
    } mem_e;

    typedef enum logic [2:0] {
        imm_none, imm_sign16, imm_zero16, imm_shamt, imm_link
    } imm_kind_e;

    typedef enum logic [1:0] {
        tgt_none, tgt_branch, tgt_index
    } target_kind_e;

    //////////////////////////////////////////////////
    // stage payloads

    typedef struct packed {
        addr_t pc;
        data_t raw_inst;
    } fetch_item_t;

    typedef struct packed {
        addr_t       pc;
        logic [5:0]  op;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
        logic [15:0] imm16;
        logic [25:0] index26;
    } field_item_t;

    typedef struct packed {
        addr_t        pc;
        logic [15:0]  imm16;
        logic [25:0]  index26;
        imm_kind_e    imm_kind;
        target_kind_e target_kind;
        reg_idx_t     rs;
        reg_idx_t     rt;
        reg_idx_t     rd;
        logic         rs_en;
        logic         rt_en;
        logic         wb_reg;
        alu_op_e      alu_op;
        logic         b_imm;    // operand b is the immediate
        mem_e         mem;
        logic         wb_mem;   // write back from memory
        jump_e        jump;
        logic         branch;
        logic         illegal;
    } ctrl_item_t;

    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_en;
        logic     rt_en;
        logic     wb_reg;
        alu_op_e  alu_op;
        data_t    imm;
        addr_t    target;
        logic     b_imm;
        mem_e     mem;
        logic     wb_mem;
        jump_e    jump;
        logic     branch;
        logic     illegal;
    } decoded_t;

endpackage

`default_nettype wire

// ==== include/dec_cfg.svh ====
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

//////////////////////////////////////////////////
// widths

// word address
`define DEC_ADDR_WIDTH 18
`define DEC_DATA_WIDTH 32
`define DEC_REG_WIDTH 5

//////////////////////////////////////////////////
// flow control and link

// items the consumer can hold
`define DEC_CREDITS 4
// pc + 2 skips the delay slot
`define DEC_LINK_OFFSET 2
`define DEC_LINK_REG 31

`endif
